/* design/alu.sv */
`default_nettype none

module alu (
    input  isaPkg::opcodeT     aluOp,
    input  datapathPkg::wordT  y,
    input  datapathPkg::wordT  b,
    output datapathPkg::dwordT result
);

    logic [datapathPkg::shiftWidth-1:0] shiftAmount;
    datapathPkg::dwordT rotPair;
    datapathPkg::dwordT rorPair;
    datapathPkg::dwordT rolPair;
    datapathPkg::wordT shraValue;
    logic signed [2*datapathPkg::wordWidth-1:0] product;

    assign shiftAmount = b[datapathPkg::shiftWidth-1:0];

    // rotates shift a doubled copy of y and pick one half
    assign rotPair = {y, y};
    assign rorPair = rotPair >> shiftAmount;
    assign rolPair = rotPair << shiftAmount;

    assign shraValue = $signed(y) >>> shiftAmount;

    // full signed product, both operands extended to 64 bits
    assign product = $signed(y) * $signed(b);

    always_comb begin
        result = '0; // high word stays zero except for mul
        case (aluOp)
            isaPkg::opAdd: begin
                result[datapathPkg::wordWidth-1:0] = y + b;
            end
            isaPkg::opSub: begin
                result[datapathPkg::wordWidth-1:0] = y - b;
            end
            isaPkg::opAnd: begin
                result[datapathPkg::wordWidth-1:0] = y & b;
            end
            isaPkg::opOr: begin
                result[datapathPkg::wordWidth-1:0] = y | b;
            end
            isaPkg::opRor: begin
                result[datapathPkg::wordWidth-1:0] = rorPair[datapathPkg::wordWidth-1:0];
            end
            isaPkg::opRol: begin
                result[datapathPkg::wordWidth-1:0] =
                    rolPair[2*datapathPkg::wordWidth-1:datapathPkg::wordWidth];
            end
            isaPkg::opShr: begin
                result[datapathPkg::wordWidth-1:0] = y >> shiftAmount;
            end
            isaPkg::opShra: begin
                result[datapathPkg::wordWidth-1:0] = shraValue;
            end
            isaPkg::opShl: begin
                result[datapathPkg::wordWidth-1:0] = y << shiftAmount;
            end
            isaPkg::opMul: begin
                result = product;
            end
            isaPkg::opNeg: begin
                result[datapathPkg::wordWidth-1:0] = -b;
            end
            isaPkg::opNot: begin
                result[datapathPkg::wordWidth-1:0] = ~b;
            end
            default: begin
                result[datapathPkg::wordWidth-1:0] = b; // pass the bus
            end
        endcase
    end

endmodule

`default_nettype wire

/* design/busMux.sv */
`default_nettype none

module busMux (
    input  logic                Clock,
    input  datapathPkg::busSrcT src,
    input  datapathPkg::wordT   pc,
    input  datapathPkg::wordT   zHigh,
    input  datapathPkg::wordT   zLow,
    input  datapathPkg::wordT   mdr,
    input  datapathPkg::wordT   hi,
    input  datapathPkg::wordT   lo,
    input  datapathPkg::wordT   cValue,
    input  datapathPkg::wordT   regValue,
    output datapathPkg::wordT   bus
);

    // and-or mux, an idle bus reads zero
    always_comb begin
        bus = '0;
        if (src.pcOut) begin
            bus = bus | pc;
        end
        if (src.zHighOut) begin
            bus = bus | zHigh;
        end
        if (src.zLowOut) begin
            bus = bus | zLow;
        end
        if (src.mdrOut) begin
            bus = bus | mdr;
        end
        if (src.hiOut) begin
            bus = bus | hi;
        end
        if (src.loOut) begin
            bus = bus | lo;
        end
        if (src.cOut) begin
            bus = bus | cValue;
        end
        if (src.regOut) begin
            bus = bus | regValue; // already narrowed to one register by decode
        end
    end

    busSrcOneHot: assert property (
        @(posedge Clock) $onehot0(src)
    ) else $error("busMux: more than one bus source strobe active");

endmodule

`default_nettype wire

/* design/dataRegister.sv */
`default_nettype none

module dataRegister #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    Clock,
    input  logic    rstN,
    input  logic    load,
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge Clock) begin
        if (!rstN) begin
            q <= '0;
        end else if (load) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* design/datapath.sv */
`default_nettype none

module datapath (
    input  logic              Clock,
    input  logic              rstN,
    input  datapathPkg::ctrlT ctrl,
    input  datapathPkg::wordT memDataIn,
    output datapathPkg::wordT busValue,
    output datapathPkg::wordT memAddr,
    output datapathPkg::wordT memDataOut
);

    datapathPkg::wordT bus;
    datapathPkg::wordT pc;
    datapathPkg::wordT pcNext;
    datapathPkg::wordT irWord;
    datapathPkg::wordT y;
    datapathPkg::wordT zHigh;
    datapathPkg::wordT zLow;
    datapathPkg::wordT hi;
    datapathPkg::wordT lo;
    datapathPkg::wordT cValue;
    datapathPkg::wordT regValue;
    datapathPkg::dwordT aluResult;
    isaPkg::regSelT regLoad;
    isaPkg::regSelT regRead;
    isaPkg::opcodeT aluOp;

    assign busValue = bus;
    assign pcNext = ctrl.incPc ? pc + 1'b1 : bus; // increment bypasses the bus

    dataRegister #(.payloadT(datapathPkg::wordT)) i_pcReg (
        .Clock(Clock), .rstN(rstN), .load(ctrl.pcIn), .d(pcNext), .q(pc)
    );

    dataRegister #(.payloadT(datapathPkg::wordT)) i_irReg (
        .Clock(Clock), .rstN(rstN), .load(ctrl.irIn), .d(bus), .q(irWord)
    );

    dataRegister #(.payloadT(datapathPkg::wordT)) i_yReg (
        .Clock(Clock), .rstN(rstN), .load(ctrl.yIn), .d(bus), .q(y)
    );

    selectEncode i_selectEncode (
        .Clock(Clock), .ir(isaPkg::instrT'(irWord)),
        .gra(ctrl.gra), .grb(ctrl.grb), .grc(ctrl.grc),
        .regIn(ctrl.regIn), .regOut(ctrl.src.regOut),
        .regLoad(regLoad), .regRead(regRead), .aluOp(aluOp), .cValue(cValue)
    );

    registerFile i_registerFile (
        .Clock(Clock), .rstN(rstN), .regLoad(regLoad), .regRead(regRead),
        .bus(bus), .regValue(regValue)
    );

    alu i_alu (.aluOp(aluOp), .y(y), .b(bus), .result(aluResult));

    resultStage i_resultStage (
        .Clock(Clock), .rstN(rstN), .zIn(ctrl.zIn), .hiIn(ctrl.hiIn), .loIn(ctrl.loIn),
        .aluResult(aluResult), .bus(bus), .zHigh(zHigh), .zLow(zLow), .hi(hi), .lo(lo)
    );

    memoryInterface i_memoryInterface (
        .Clock(Clock), .rstN(rstN), .marIn(ctrl.marIn), .mdrIn(ctrl.mdrIn),
        .read(ctrl.read), .bus(bus), .memDataIn(memDataIn),
        .memAddr(memAddr), .mdr(memDataOut)
    );

    busMux i_busMux (
        .Clock(Clock), .src(ctrl.src), .pc(pc), .zHigh(zHigh), .zLow(zLow),
        .mdr(memDataOut), .hi(hi), .lo(lo), .cValue(cValue), .regValue(regValue),
        .bus(bus)
    );

endmodule

`default_nettype wire

/* design/datapathPkg.sv */
`default_nettype none

package datapathPkg;

    localparam int wordWidth = 32;
    localparam int shiftWidth = $clog2(wordWidth);

    typedef logic [wordWidth-1:0] wordT;
    typedef logic [2*wordWidth-1:0] dwordT;

    // bus drivers, at most one per cycle
    typedef struct packed {
        logic pcOut;
        logic zHighOut;
        logic zLowOut;
        logic mdrOut;
        logic hiOut;
        logic loOut;
        logic cOut;
        logic regOut; // gated by decode into one register
    } busSrcT;

    typedef struct packed {
        logic marIn;
        logic mdrIn;
        logic pcIn;
        logic irIn;
        logic yIn;
        logic zIn;
        logic hiIn;
        logic loIn;
        logic regIn; // gated by decode like regOut
        logic read; // MDR takes memory data instead of the bus
        logic incPc;
        logic gra;
        logic grb;
        logic grc;
        busSrcT src;
    } ctrlT;

endpackage

`default_nettype wire

/* design/isaPkg.sv */
`default_nettype none

package isaPkg;

    localparam int regCount = 16;
    localparam int opcodeWidth = 5;
    localparam int regFieldWidth = 4;
    localparam int constWidth = 15;

    // one bit per general register, used for both load and read selects
    typedef logic [regCount-1:0] regSelT;

    typedef enum logic [opcodeWidth-1:0] {
        opAdd  = 5'd3,
        opSub  = 5'd4,
        opAnd  = 5'd5,
        opOr   = 5'd6,
        opRor  = 5'd7,
        opRol  = 5'd8,
        opShr  = 5'd9,
        opShra = 5'd10,
        opShl  = 5'd11,
        opMul  = 5'd15,
        opNeg  = 5'd17,
        opNot  = 5'd18
    } opcodeT; // unlisted codes pass the bus through the ALU

    typedef struct packed {
        opcodeT opcode; // [31:27]
        logic [regFieldWidth-1:0] ra; // [26:23]
        logic [regFieldWidth-1:0] rb; // [22:19]
        logic [regFieldWidth-1:0] rc; // [18:15]
        logic [constWidth-1:0] constant; // two's complement
    } instrT;

endpackage

`default_nettype wire

/* design/memoryInterface.sv */
`default_nettype none

module memoryInterface (
    input  logic              Clock,
    input  logic              rstN,
    input  logic              marIn,
    input  logic              mdrIn,
    input  logic              read,
    input  datapathPkg::wordT bus,
    input  datapathPkg::wordT memDataIn,
    output datapathPkg::wordT memAddr,
    output datapathPkg::wordT mdr
);

    datapathPkg::wordT mdrNext;

    assign mdrNext = read ? memDataIn : bus; // memory word on a read

    dataRegister #(
        .payloadT(datapathPkg::wordT)
    ) i_marReg (
        .Clock(Clock),
        .rstN(rstN),
        .load(marIn),
        .d(bus),
        .q(memAddr)
    );

    dataRegister #(
        .payloadT(datapathPkg::wordT)
    ) i_mdrReg (
        .Clock(Clock),
        .rstN(rstN),
        .load(mdrIn),
        .d(mdrNext),
        .q(mdr)
    );

endmodule

`default_nettype wire

/* design/registerFile.sv */
`default_nettype none

module registerFile (
    input  logic              Clock,
    input  logic              rstN,
    input  isaPkg::regSelT    regLoad,
    input  isaPkg::regSelT    regRead,
    input  datapathPkg::wordT bus,
    output datapathPkg::wordT regValue
);

    datapathPkg::wordT regQ [isaPkg::regCount];

    for (genvar i = 0; i < isaPkg::regCount; i++) begin : gReg
        dataRegister #(
            .payloadT(datapathPkg::wordT)
        ) i_generalReg (
            .Clock(Clock),
            .rstN(rstN),
            .load(regLoad[i]),
            .d(bus),
            .q(regQ[i])
        );
    end

    // and-or read mux, zero when nothing is selected
    always_comb begin
        regValue = '0;
        for (int j = 0; j < isaPkg::regCount; j++) begin
            if (regRead[j]) begin
                regValue = regValue | regQ[j];
            end
        end
    end

    // decode must never open two registers onto the bus
    regReadOneHot: assert property (
        @(posedge Clock) disable iff (!rstN)
        $onehot0(regRead)
    ) else $error("registerFile: regRead selects more than one register");

endmodule

`default_nettype wire

/* design/resultStage.sv */
`default_nettype none

module resultStage (
    input  logic               Clock,
    input  logic               rstN,
    input  logic               zIn,
    input  logic               hiIn,
    input  logic               loIn,
    input  datapathPkg::dwordT aluResult,
    input  datapathPkg::wordT  bus,
    output datapathPkg::wordT  zHigh,
    output datapathPkg::wordT  zLow,
    output datapathPkg::wordT  hi,
    output datapathPkg::wordT  lo
);

    datapathPkg::dwordT z;

    dataRegister #(
        .payloadT(datapathPkg::dwordT)
    ) i_zReg (
        .Clock(Clock),
        .rstN(rstN),
        .load(zIn),
        .d(aluResult),
        .q(z)
    );

    assign zHigh = z[2*datapathPkg::wordWidth-1:datapathPkg::wordWidth];
    assign zLow = z[datapathPkg::wordWidth-1:0];

    // hi and lo are filled from the bus, usually right after a mul
    dataRegister #(
        .payloadT(datapathPkg::wordT)
    ) i_hiReg (
        .Clock(Clock),
        .rstN(rstN),
        .load(hiIn),
        .d(bus),
        .q(hi)
    );

    dataRegister #(
        .payloadT(datapathPkg::wordT)
    ) i_loReg (
        .Clock(Clock),
        .rstN(rstN),
        .load(loIn),
        .d(bus),
        .q(lo)
    );

endmodule

`default_nettype wire

/* design/selectEncode.sv */
`default_nettype none

module selectEncode (
    input  logic              Clock,
    input  isaPkg::instrT     ir,
    input  logic              gra,
    input  logic              grb,
    input  logic              grc,
    input  logic              regIn,
    input  logic              regOut,
    output isaPkg::regSelT    regLoad,
    output isaPkg::regSelT    regRead,
    output isaPkg::opcodeT    aluOp,
    output datapathPkg::wordT cValue
);

    logic [isaPkg::regFieldWidth-1:0] regField;
    isaPkg::regSelT regDecoded;

    always_comb begin
        regField = '0;
        if (gra) begin
            regField = ir.ra;
        end else if (grb) begin
            regField = ir.rb;
        end else if (grc) begin
            regField = ir.rc;
        end
    end

    always_comb begin
        regDecoded = '0;
        if (gra || grb || grc) begin
            regDecoded[regField] = 1'b1; // no field chosen, no register
        end
    end

    assign regLoad = regIn ? regDecoded : '0;
    assign regRead = regOut ? regDecoded : '0;

    assign aluOp = ir.opcode;

    // sign extend the constant field to a full word
    assign cValue = {
        {(datapathPkg::wordWidth - isaPkg::constWidth){ir.constant[isaPkg::constWidth-1]}},
        ir.constant
    };

    gStrobeOneHot: assert property (
        @(posedge Clock) $onehot0({gra, grb, grc})
    ) else $error("selectEncode: more than one of gra, grb, grc active");

endmodule

`default_nettype wire

/* project.f */
design/isaPkg.sv
design/datapathPkg.sv
design/dataRegister.sv
design/registerFile.sv
design/selectEncode.sv
design/alu.sv
design/resultStage.sv
design/memoryInterface.sv
design/busMux.sv
design/datapath.sv
test/clockGen.sv
test/datapathTb.sv

/* test/clockGen.sv */
`default_nettype none

module clockGen (
    output logic Clock,
    output logic rstN
);

    localparam int halfPeriod = 20;
    localparam int resetCycles = 10;

    initial begin
        Clock = 1'b0;
        forever #halfPeriod Clock = ~Clock;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge Clock);
        rstN <= 1'b1; // released on an edge, like the rest of the stimulus
    end

endmodule

`default_nettype wire

/* test/datapathTb.sv */
`default_nettype none

module datapathTb;

    localparam int operandCount = 8;
    localparam int resetTimeout = 40;
    localparam int watchdogCycles = 3000;

    logic Clock;
    logic rstN;
    datapathPkg::ctrlT ctrl;
    datapathPkg::wordT memDataIn;
    datapathPkg::wordT busValue;
    datapathPkg::wordT memAddr;
    datapathPkg::wordT memDataOut;

    logic checkBus;
    datapathPkg::wordT expectBus;
    datapathPkg::wordT regModel [isaPkg::regCount];
    datapathPkg::wordT pcModel;
    logic [15:0] lfsrState;
    int errorCount = 0;
    int errorsBefore = 0;
    int testCount = 0;
    int failedTests = 0;

    isaPkg::opcodeT aluOps [12] = '{
        isaPkg::opAdd, isaPkg::opSub, isaPkg::opAnd, isaPkg::opOr, isaPkg::opRor,
        isaPkg::opRol, isaPkg::opShr, isaPkg::opShra, isaPkg::opShl, isaPkg::opMul,
        isaPkg::opNeg, isaPkg::opNot
    };

    clockGen i_clockGen (.Clock(Clock), .rstN(rstN));

    datapath i_datapath (
        .Clock(Clock), .rstN(rstN), .ctrl(ctrl), .memDataIn(memDataIn),
        .busValue(busValue), .memAddr(memAddr), .memDataOut(memDataOut)
    );

    task automatic reportMismatch(input string what, input datapathPkg::wordT got,
                                  input datapathPkg::wordT exp);
        errorCount++;
        $display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    // the value driven in a cycle is checked at the edge that closes it
    busMatches: assert property (
        @(posedge Clock) disable iff (!rstN)
        checkBus |-> busValue == expectBus
    ) else reportMismatch("bus", $sampled(busValue), $sampled(expectBus));

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic datapathPkg::wordT randomBits(input int count);
        datapathPkg::wordT w;
        w = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
        return w;
    endfunction

    function automatic datapathPkg::wordT makeInstr(input logic [4:0] op,
            input logic [3:0] ra, input logic [3:0] rb, input logic [3:0] rc,
            input logic [14:0] konst);
        return {op, ra, rb, rc, konst};
    endfunction

    function automatic datapathPkg::wordT signExtend(input logic [14:0] konst);
        return {{17{konst[14]}}, konst};
    endfunction

    function automatic datapathPkg::dwordT aluModel(input isaPkg::opcodeT op,
            input datapathPkg::wordT y, input datapathPkg::wordT b);
        logic [4:0] s;
        datapathPkg::wordT low;
        s = b[4:0];
        low = b;
        case (op)
            isaPkg::opAdd: low = y + b;
            isaPkg::opSub: low = y - b;
            isaPkg::opAnd: low = y & b;
            isaPkg::opOr: low = y | b;
            isaPkg::opRor: low = (y >> s) | (y << (32 - s)); // a shift of 32 gives zero
            isaPkg::opRol: low = (y << s) | (y >> (32 - s));
            isaPkg::opShr: low = y >> s;
            isaPkg::opShra: low = $signed(y) >>> s;
            isaPkg::opShl: low = y << s;
            isaPkg::opMul: return longint'($signed(y)) * longint'($signed(b));
            isaPkg::opNeg: low = -b;
            isaPkg::opNot: low = ~b;
            default: low = b;
        endcase
        return {32'd0, low};
    endfunction

    function automatic datapathPkg::ctrlT selectField(input datapathPkg::ctrlT c,
                                                      input int field);
        c.gra = (field == 0);
        c.grb = (field == 1);
        c.grc = (field == 2);
        return c;
    endfunction

    task automatic step(input datapathPkg::ctrlT c, input datapathPkg::wordT data,
                        input logic check, input datapathPkg::wordT exp);
        @(posedge Clock);
        ctrl <= c;
        memDataIn <= data;
        checkBus <= check;
        expectBus <= exp;
    endtask

    task automatic loadIr(input datapathPkg::wordT instr);
        datapathPkg::ctrlT c;
        c = '0;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        step(c, instr, 1'b0, '0);
        c = '0;
        c.src.mdrOut = 1'b1;
        c.irIn = 1'b1;
        step(c, '0, 1'b1, instr);
    endtask

    task automatic loadReg(input int field, input int idx, input datapathPkg::wordT value);
        datapathPkg::ctrlT c;
        c = '0;
        c.read = 1'b1;
        c.mdrIn = 1'b1;
        step(c, value, 1'b0, '0);
        c = '0;
        c.src.mdrOut = 1'b1;
        c.regIn = 1'b1;
        step(selectField(c, field), '0, 1'b1, value);
        regModel[idx] = value;
    endtask

    task automatic readReg(input int field, input datapathPkg::wordT exp);
        datapathPkg::ctrlT c;
        c = '0;
        c.src.regOut = 1'b1;
        step(selectField(c, field), '0, 1'b1, exp);
    endtask

    task automatic busOnly(input datapathPkg::busSrcT src, input datapathPkg::wordT exp);
        datapathPkg::ctrlT c;
        c = '0;
        c.src = src;
        step(c, '0, 1'b1, exp);
    endtask

    task automatic finishTest(input string name);
        step('0, '0, 1'b0, '0);
        @(negedge Clock); // last check has run by now
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, errorCount - errorsBefore);
        end
        errorsBefore = errorCount;
    endtask

    initial begin
        for (int cycles = 0; cycles < watchdogCycles; cycles++) begin
            @(posedge Clock);
        end
        $display("timeout: the test sequence did not finish in %0d cycles", watchdogCycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        datapathPkg::ctrlT c;
        datapathPkg::busSrcT src;
        datapathPkg::wordT w;
        datapathPkg::dwordT result;
        logic [14:0] k;
        int idx;
        int ra;
        int rb;
        int rc;
        int waited;

        ctrl <= '0;
        memDataIn <= '0;
        checkBus <= 1'b0;
        expectBus <= '0;
        lfsrState = 16'd26973;
        pcModel = '0;
        foreach (regModel[r]) begin
            regModel[r] = '0;
        end

        waited = 0;
        while (rstN !== 1'b1 && waited < resetTimeout) begin
            @(posedge Clock);
            waited++;
        end
        if (rstN !== 1'b1) begin
            $display("timeout: reset was never released");
            $display("TEST FAILED");
            $finish;
        end

        step('0, '0, 1'b1, '0); // idle bus reads zero
        for (int r = 0; r < isaPkg::regCount; r++) begin
            loadIr(makeInstr(5'd0, 4'(r), 4'(r), 4'(r), 15'd0));
            for (int f = 0; f < 3; f++) begin
                readReg(f, '0);
            end
        end
        finishTest("reset values");

        for (int n = 0; n < operandCount; n++) begin
            idx = randomBits(4);
            w = randomBits(32);
            loadIr(makeInstr(5'd0, 4'(idx), 4'(idx ^ 1), 4'(idx ^ 2), 15'd0));
            loadReg(0, idx, w);
            readReg(0, w);
            readReg(1, regModel[idx ^ 1]);
            @(negedge Clock);
            mdrHolds: assert (memDataOut == w)
                else reportMismatch("memDataOut", memDataOut, w);
        end
        finishTest("load through MDR");

        for (int n = 0; n < 3; n++) begin
            c = '0;
            c.src.pcOut = 1'b1;
            c.marIn = 1'b1;
            c.incPc = 1'b1;
            c.pcIn = 1'b1;
            step(c, '0, 1'b1, pcModel);
            pcModel = pcModel + 1;
            src = '0;
            src.pcOut = 1'b1;
            busOnly(src, pcModel);
            @(negedge Clock);
            marHolds: assert (memAddr == pcModel - 1)
                else reportMismatch("memAddr", memAddr, pcModel - 1);
        end
        loadIr(32'h18228000);
        readReg(1, regModel[4]); // fields of 18228000 are rb 4 and rc 5
        readReg(2, regModel[5]);
        finishTest("fetch");

        foreach (aluOps[i]) begin
            rb = randomBits(4);
            rc = (rb + 1 + randomBits(3)) % isaPkg::regCount; // never equal to rb
            ra = randomBits(4);
            loadIr(makeInstr(aluOps[i], 4'(ra), 4'(rb), 4'(rc), 15'd0));
            loadReg(1, rb, randomBits(32));
            loadReg(2, rc, randomBits(32));
            result = aluModel(aluOps[i], regModel[rb], regModel[rc]);
            c = '0;
            c.src.regOut = 1'b1;
            c.yIn = 1'b1;
            step(selectField(c, 1), '0, 1'b1, regModel[rb]); // T3
            c = '0;
            c.src.regOut = 1'b1;
            c.zIn = 1'b1;
            step(selectField(c, 2), '0, 1'b1, regModel[rc]); // T4
            c = '0;
            c.src.zLowOut = 1'b1;
            c.regIn = 1'b1;
            step(selectField(c, 0), '0, 1'b1, result[31:0]); // T5
            regModel[ra] = result[31:0];
            readReg(0, result[31:0]);
            if (aluOps[i] == isaPkg::opMul) begin
                c = '0;
                c.src.zHighOut = 1'b1;
                c.hiIn = 1'b1;
                step(c, '0, 1'b1, result[63:32]);
                c = '0;
                c.src.zLowOut = 1'b1;
                c.loIn = 1'b1;
                step(c, '0, 1'b1, result[31:0]);
                src = '0;
                src.hiOut = 1'b1;
                busOnly(src, result[63:32]);
                src = '0;
                src.loOut = 1'b1;
                busOnly(src, result[31:0]);
            end
        end
        finishTest("ALU operations");

        for (int n = 0; n < 4; n++) begin
            w = randomBits(15);
            k = w[14:0];
            k[14] = n[0]; // negative and positive constants in turn
            loadIr(makeInstr(5'd0, 4'd0, 4'd0, 4'd0, k));
            src = '0;
            src.cOut = 1'b1;
            busOnly(src, signExtend(k));
        end
        finishTest("constant path");

        $display("tests %0d, failed tests %0d, failed checks %0d",
                 testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
